//--- Makefile
# Verilator build and run of the scaler testbench

VERILATOR ?= verilator
TOP ?= tb_axis_scaler
SEED ?= 2118348914
OBJ_DIR ?= obj_dir
FILELIST ?= filelist.f

VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench (TOP, SEED, VERILATOR may be overridden)"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GSEED=$(SEED) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- filelist.f
verilog/scaler_types_pkg.sv
verilog/scaler_ctrl_pkg.sv
verilog/line_buffer.sv
verilog/scale_stepper.sv
verilog/scaler_fsm.sv
verilog/axis_scaler.sv
tb/tb_axis_scaler.sv

//--- tb/tb_axis_scaler.sv
`timescale 1ns/1ps

module tb_axis_scaler;
	import scaler_types_pkg::*;

	parameter int SEED = 32'h7e437072;

	// All source and output pixels of the run, junk beats included
	localparam int PIX_TOTAL = 3600 + 100 + 100 + 384 + 64 + 64 + 64 + 64 + 72 + 54 + 3;
	localparam int CYCLE_LIMIT = 4 * PIX_TOTAL + 2000;

	logic clk;
	logic resetn_tb;
	logic fsync;
	dim_t cur_sw;
	dim_t cur_sh;
	dim_t cur_mw;
	dim_t cur_mh;
	pixel_t s_tdata;
	logic s_tvalid;
	logic s_tready;
	logic s_tuser;
	logic s_tlast;
	pixel_t m_tdata;
	logic m_tvalid;
	logic m_tready;
	logic m_tuser;
	logic m_tlast;

	int seed;
	logic rand_ready;	// Random back-pressure on the output
	logic xfer;
	int out_r;
	int out_c;
	int rx_count;
	int cycles;
	logic fsync_seen;
	logic stall_q;
	pixel_t data_q;
	logic user_q;
	logic last_q;

	axis_scaler u_dut (
		.clk(clk),
		.resetn(resetn_tb),
		.fsync(fsync),
		.s_width(cur_sw),
		.s_height(cur_sh),
		.m_width(cur_mw),
		.m_height(cur_mh),
		.s_tdata(s_tdata),
		.s_tvalid(s_tvalid),
		.s_tready(s_tready),
		.s_tuser(s_tuser),
		.s_tlast(s_tlast),
		.m_tdata(m_tdata),
		.m_tvalid(m_tvalid),
		.m_tready(m_tready),
		.m_tuser(m_tuser),
		.m_tlast(m_tlast)
	);

	always #2 clk = ~clk;

	assign xfer = m_tvalid && m_tready;

	task automatic fail_value(input string msg);
		$display("ERR %0t: %s", $time, msg);
		$display("Checks failed");
		$fatal(1);
	endtask

	// Nearest source pixel for output (r, c)
	function automatic pixel_t expected_pixel(input int r, input int c);
		int sr;
		int sc;
		sr = (r * int'(cur_sh)) / int'(cur_mh);
		sc = (c * int'(cur_sw)) / int'(cur_mw);
		return pixel_t'(sr * 256 + sc);
	endfunction

	always @(negedge clk) begin
		if (rand_ready)
			m_tready <= ($random(seed) & 3) != 0;
		else
			m_tready <= 1'b1;
	end

	// Output position of each transfer
	always @(posedge clk) begin
		if (!resetn_tb || fsync) begin
			out_r <= 0;
			out_c <= 0;
			rx_count <= 0;
		end else if (xfer) begin
			rx_count <= rx_count + 1;
			if (out_c == int'(cur_mw) - 1) begin
				out_c <= 0;
				out_r <= out_r + 1;
			end else begin
				out_c <= out_c + 1;
			end
		end
	end

	always @(posedge clk) begin
		if (!resetn_tb) begin
			fsync_seen <= 1'b0;
			stall_q <= 1'b0;
		end else begin
			if (fsync)
				fsync_seen <= 1'b1;
			stall_q <= m_tvalid && !m_tready;
			data_q <= m_tdata;
			user_q <= m_tuser;
			last_q <= m_tlast;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run went past %0d cycles", CYCLE_LIMIT);
			$display("Checks failed");
			$fatal(1);
		end
	end

	a_pixel: assert property (@(posedge clk) disable iff (!resetn_tb)
		xfer |-> (m_tdata == expected_pixel(out_r, out_c)))
		else fail_value($sformatf("pixel r%0d c%0d got %h exp %h", out_r, out_c,
			m_tdata, expected_pixel(out_r, out_c)));

	a_in_frame: assert property (@(posedge clk) disable iff (!resetn_tb)
		xfer |-> (out_r < int'(cur_mh)))
		else fail_value($sformatf("extra output pixel in row %0d", out_r));

	a_user: assert property (@(posedge clk) disable iff (!resetn_tb)
		xfer |-> (m_tuser == (out_r == 0 && out_c == 0)))
		else fail_value($sformatf("m_tuser %b at r%0d c%0d", m_tuser, out_r, out_c));

	a_last: assert property (@(posedge clk) disable iff (!resetn_tb)
		xfer |-> (m_tlast == (out_c == int'(cur_mw) - 1)))
		else fail_value($sformatf("m_tlast %b at r%0d c%0d", m_tlast, out_r, out_c));

	// Output held under back-pressure
	a_stall: assert property (@(posedge clk) disable iff (!resetn_tb)
		stall_q |-> (m_tvalid && m_tdata == data_q && m_tuser == user_q
			&& m_tlast == last_q))
		else fail_value("output changed while stalled");

	a_quiet: assert property (@(posedge clk) disable iff (!resetn_tb)
		!fsync_seen |-> (!m_tvalid && !s_tready))
		else fail_value("stream active before fsync");

	// Called on a falling edge, returns on the falling edge after the transfer
	task automatic send_beat(input pixel_t data, input logic user, input logic last);
		s_tdata = data;
		s_tuser = user;
		s_tlast = last;
		while (!s_tvalid) begin
			if (($random(seed) & 3) != 0)
				s_tvalid = 1'b1;
			else
				@(negedge clk);
		end
		while (!s_tready)
			@(negedge clk);	// s_tready only moves on the rising edge
		@(negedge clk);
		s_tvalid = 1'b0;
	endtask

	task automatic run_frame(input int sw, input int sh, input int mw, input int mh,
		input int junk);
		@(negedge clk);
		cur_sw = dim_t'(sw);
		cur_sh = dim_t'(sh);
		cur_mw = dim_t'(mw);
		cur_mh = dim_t'(mh);
		fsync = 1'b1;
		@(negedge clk);
		fsync = 1'b0;
		for (int j = 0; j < junk; j++)
			send_beat(16'hdead, 1'b0, 1'b0);
		for (int r = 0; r < sh; r++) begin
			for (int c = 0; c < sw; c++)
				send_beat(pixel_t'(r * 256 + c), r == 0 && c == 0, c == sw - 1);
		end
		while (rx_count != mw * mh)
			@(negedge clk);
		repeat (4) @(negedge clk);	// DRAIN back to IDLE
	endtask

	initial begin
		seed = SEED;
		clk = 1'b0;
		resetn_tb = 1'b0;
		fsync = 1'b0;
		cur_sw = dim_t'(1);
		cur_sh = dim_t'(1);
		cur_mw = dim_t'(1);
		cur_mh = dim_t'(1);
		s_tdata = '0;
		s_tvalid = 1'b0;
		s_tuser = 1'b0;
		s_tlast = 1'b0;
		m_tready = 1'b0;
		rand_ready = 1'b1;
		cycles = 0;
		repeat (5) @(negedge clk);
		resetn_tb = 1'b1;
		repeat (10) @(negedge clk);	// Nothing may leave before fsync

		run_frame(60, 60, 10, 10, 0);
		run_frame(10, 10, 24, 16, 0);
		rand_ready = 1'b0;
		run_frame(8, 8, 8, 8, 0);
		run_frame(8, 8, 8, 8, 0);
		rand_ready = 1'b1;
		run_frame(12, 6, 6, 9, 3);

		$display("All checks passed");
		$finish;
	end

endmodule

//--- verilog/axis_scaler.sv
`timescale 1ns/1ps

module axis_scaler (
	input  logic clk,
	input  logic resetn,
	input  logic fsync,
	input  scaler_types_pkg::dim_t s_width,
	input  scaler_types_pkg::dim_t s_height,
	input  scaler_types_pkg::dim_t m_width,
	input  scaler_types_pkg::dim_t m_height,
	input  scaler_types_pkg::pixel_t s_tdata,
	input  logic s_tvalid,
	output logic s_tready,
	input  logic s_tuser,
	input  logic s_tlast,
	output scaler_types_pkg::pixel_t m_tdata,
	output logic m_tvalid,
	input  logic m_tready,
	output logic m_tuser,
	output logic m_tlast
);
	import scaler_types_pkg::*;

	logic frame_start;
	logic src_row_end;
	logic out_row_end;
	logic col_take;
	logic col_skip;
	logic row_needed;
	logic src_rows_done;
	logic col_match;
	logic cols_done;
	logic wr_en;
	logic rd_en;
	addr_t wr_addr;
	addr_t rd_addr;

	scaler_fsm u_fsm (
		.clk(clk),
		.resetn(resetn),
		.fsync(fsync),
		.s_tvalid(s_tvalid),
		.s_tuser(s_tuser),
		.s_tlast(s_tlast),
		.m_tready(m_tready),
		.row_needed(row_needed),
		.src_rows_done(src_rows_done),
		.col_match(col_match),
		.cols_done(cols_done),
		.s_tready(s_tready),
		.m_tvalid(m_tvalid),
		.m_tuser(m_tuser),
		.m_tlast(m_tlast),
		.frame_start(frame_start),
		.src_row_end(src_row_end),
		.out_row_end(out_row_end),
		.col_take(col_take),
		.col_skip(col_skip),
		.wr_en(wr_en),
		.rd_en(rd_en)
	);

	scale_stepper u_stepper (
		.clk(clk),
		.resetn(resetn),
		.frame_start(frame_start),
		.src_row_end(src_row_end),
		.out_row_end(out_row_end),
		.col_take(col_take),
		.col_skip(col_skip),
		.s_width(s_width),
		.s_height(s_height),
		.m_width(m_width),
		.m_height(m_height),
		.wr_en(wr_en),
		.row_needed(row_needed),
		.src_rows_done(src_rows_done),
		.col_match(col_match),
		.cols_done(cols_done),
		.wr_addr(wr_addr),
		.rd_addr(rd_addr)
	);

	// Read data goes straight to the output stream
	line_buffer u_line (
		.clk(clk),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(s_tdata),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_data(m_tdata)
	);

endmodule

//--- verilog/line_buffer.sv
`timescale 1ns/1ps

module line_buffer (
	input  logic clk,
	input  logic wr_en,
	input  scaler_types_pkg::addr_t wr_addr,
	input  scaler_types_pkg::pixel_t wr_data,
	input  logic rd_en,
	input  scaler_types_pkg::addr_t rd_addr,
	output scaler_types_pkg::pixel_t rd_data
);
	import scaler_types_pkg::*;

	pixel_t mem [LINE_DEPTH];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// Read register doubles as the output data register
	always_ff @(posedge clk) begin
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

//--- verilog/scale_stepper.sv
`timescale 1ns/1ps

module scale_stepper (
	input  logic clk,
	input  logic resetn,
	input  logic frame_start,
	input  logic src_row_end,
	input  logic out_row_end,
	input  logic col_take,
	input  logic col_skip,
	input  scaler_types_pkg::dim_t s_width,
	input  scaler_types_pkg::dim_t s_height,
	input  scaler_types_pkg::dim_t m_width,
	input  scaler_types_pkg::dim_t m_height,
	input  logic wr_en,
	output logic row_needed,
	output logic src_rows_done,
	output logic col_match,
	output logic cols_done,
	output scaler_types_pkg::addr_t wr_addr,
	output scaler_types_pkg::addr_t rd_addr
);
	import scaler_types_pkg::*;

	dim_t out_rows;
	pos_t out_row_sum;	// out_rows * s_height
	dim_t src_rows;
	pos_t src_row_lim;	// (src_rows + 1) * m_height
	dim_t out_cols;
	pos_t out_col_sum;	// out_cols * s_width
	pos_t src_col_lim;	// (rd_addr + 1) * m_width

	// Row r reads source row k while k*mh <= r*sh < (k+1)*mh
	assign row_needed = (out_row_sum < src_row_lim) && (out_rows < m_height);
	assign src_rows_done = (src_rows == s_height - dim_t'(1));
	assign col_match = (out_col_sum < src_col_lim);
	assign cols_done = (out_cols == m_width - dim_t'(1));

	always_ff @(posedge clk) begin
		if (!resetn) begin
			out_rows <= '0;
			out_row_sum <= '0;
			src_rows <= '0;
			src_row_lim <= '0;
		end else if (frame_start) begin
			out_rows <= '0;
			out_row_sum <= '0;
			src_rows <= '0;
			src_row_lim <= pos_t'(m_height);
		end else begin
			if (out_row_end) begin
				out_rows <= out_rows + dim_t'(1);
				out_row_sum <= out_row_sum + pos_t'(s_height);
			end
			if (src_row_end) begin
				src_rows <= src_rows + dim_t'(1);
				src_row_lim <= src_row_lim + pos_t'(m_height);
			end
		end
	end

	// Column DDA restarts on every output row
	always_ff @(posedge clk) begin
		if (!resetn || frame_start || out_row_end) begin
			out_cols <= '0;
			out_col_sum <= '0;
			rd_addr <= '0;
			src_col_lim <= pos_t'(m_width);
		end else if (col_take) begin
			out_cols <= out_cols + dim_t'(1);
			out_col_sum <= out_col_sum + pos_t'(s_width);
		end else if (col_skip) begin
			rd_addr <= rd_addr + addr_t'(1);
			src_col_lim <= src_col_lim + pos_t'(m_width);
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn || frame_start || src_row_end)
			wr_addr <= '0;
		else if (wr_en)
			wr_addr <= wr_addr + addr_t'(1);
	end

endmodule

//--- verilog/scaler_ctrl_pkg.sv
package scaler_ctrl_pkg;

	// Frame controller states
	typedef enum logic [2:0] {
		ST_IDLE,	// Waiting for fsync
		ST_SYNC,	// Dropping beats until tuser
		ST_FILL,	// Taking one source row
		ST_EMIT,	// Output rows from the line buffer
		ST_DRAIN	// Last pixel still in the output register
	} scaler_state_t;

endpackage

//--- verilog/scaler_fsm.sv
`timescale 1ns/1ps

module scaler_fsm (
	input  logic clk,
	input  logic resetn,
	input  logic fsync,
	input  logic s_tvalid,
	input  logic s_tuser,
	input  logic s_tlast,
	input  logic m_tready,
	input  logic row_needed,
	input  logic src_rows_done,
	input  logic col_match,
	input  logic cols_done,
	output logic s_tready,
	output logic m_tvalid,
	output logic m_tuser,
	output logic m_tlast,
	output logic frame_start,
	output logic src_row_end,
	output logic out_row_end,
	output logic col_take,
	output logic col_skip,
	output logic wr_en,
	output logic rd_en
);
	import scaler_ctrl_pkg::*;

	scaler_state_t state;
	scaler_state_t next_state;
	logic s_beat;
	logic out_free;
	logic emit_go;
	logic first_pend;	// Next read is the first pixel of the frame

	assign s_tready = (state == ST_SYNC) || (state == ST_FILL);
	assign s_beat = s_tvalid && s_tready;
	assign out_free = !m_tvalid || m_tready;	// Output slot empty or leaving

	assign frame_start = (state == ST_IDLE) && fsync;

	// In SYNC only the tuser beat is kept, as column 0
	assign wr_en = s_beat && row_needed && ((state == ST_FILL) || s_tuser);

	// Column stepping freezes under back-pressure
	assign emit_go = (state == ST_EMIT) && row_needed && out_free;
	assign col_skip = emit_go && !col_match;
	assign col_take = emit_go && col_match;
	assign rd_en = col_take;
	assign out_row_end = col_take && cols_done;

	// Buffered row has served every output row mapped to it
	assign src_row_end = (state == ST_EMIT) && !row_needed;

	always_comb begin
		next_state = state;
		case (state)
			ST_IDLE: begin
				if (fsync)
					next_state = ST_SYNC;
			end
			ST_SYNC: begin
				if (s_beat && s_tuser)
					next_state = s_tlast ? ST_EMIT : ST_FILL;	// Width of 1
			end
			ST_FILL: begin
				if (s_beat && s_tlast)
					next_state = ST_EMIT;
			end
			ST_EMIT: begin
				if (!row_needed)
					next_state = src_rows_done ? ST_DRAIN : ST_FILL;
			end
			ST_DRAIN: begin
				if (out_free)
					next_state = ST_IDLE;
			end
			default: next_state = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= ST_IDLE;
			first_pend <= 1'b0;
		end else begin
			state <= next_state;
			if (frame_start)
				first_pend <= 1'b1;
			else if (rd_en)
				first_pend <= 1'b0;
		end
	end

	// Flags travel with the registered read data
	always_ff @(posedge clk) begin
		if (!resetn) begin
			m_tvalid <= 1'b0;
			m_tuser <= 1'b0;
			m_tlast <= 1'b0;
		end else if (rd_en) begin
			m_tvalid <= 1'b1;
			m_tuser <= first_pend;
			m_tlast <= cols_done;
		end else if (m_tready) begin
			m_tvalid <= 1'b0;
			m_tuser <= 1'b0;
			m_tlast <= 1'b0;
		end
	end

endmodule

//--- verilog/scaler_types_pkg.sv
package scaler_types_pkg;

	// Pixel word
	localparam int PIXEL_W = 16;

	// Frame and line dimensions
	localparam int DIM_W = 12;

	// Holds a full dimension times dimension product
	localparam int POS_W = 24;

	// One source row, at most 1024 pixels wide
	localparam int LINE_DEPTH = 1024;
	localparam int ADDR_W = 10;

	typedef logic [PIXEL_W-1:0] pixel_t;
	typedef logic [DIM_W-1:0] dim_t;
	typedef logic [POS_W-1:0] pos_t;
	typedef logic [ADDR_W-1:0] addr_t;

endpackage
